//--- list.f
verilog/dcache_geom_pkg.sv
verilog/dcache_ctrl_pkg.sv
verilog/dcache_way_if.sv
verilog/dcache_way.sv
verilog/dcache_lru_sel.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   --top-module tb_dcache \
   --Mdir obj_dir -o sim_dcache \
   -f list.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator compile failed with status $status"
   exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Test OK$" sim.log; then
   exit 0
else
   echo "Pass message not found in sim.log"
   exit 1
fi

//--- test/tb_dcache.sv
`default_nettype none

module tb_dcache;
   import dcache_geom_pkg::*;
   import dcache_ctrl_pkg::*;

   localparam int CLK_PERIOD     = 100;
   localparam int RESET_CYCLES   = 8;
   localparam int NUM_RANDOM_OPS = 300;
   localparam int NUM_DIRECTED   = 40;
   localparam int MAX_GAP        = 3;
   // Cycles for lookup, worst-case refill, second lookup and slack
   localparam int OP_CYCLES      = 8 + WORDS_PER_LINE * (MAX_GAP + 1) + 8;
   localparam int TIMEOUT_CYCLES =
      RESET_CYCLES + 20 + (NUM_RANDOM_OPS + NUM_DIRECTED) * OP_CYCLES;

   logic        clk = 1'b0;
   logic        rst;
   logic        cpu_req_i;
   logic        cpu_we_i;
   addr_t       cpu_adr_i;
   data_t       cpu_dat_i;
   bsel_t       cpu_bsel_i;
   logic        cpu_ack_o;
   data_t       cpu_dat_o;
   logic        cache_hit_o;
   logic        refill_req_o;
   addr_t       refill_adr_o;
   logic        refill_we_i = 1'b0;
   data_t       refill_dat_i = '0;
   logic        refill_done_o;
   logic        spr_bus_stb_i;
   logic        spr_bus_we_i;
   logic [15:0] spr_bus_addr_i;
   data_t       spr_bus_dat_i;
   logic        spr_bus_ack_o;
   int          err_count;

   // Backing memory where untouched words keep the fill pattern
   data_t       mem [logic [ADDR_WIDTH-3:0]];

   // Refill responder state
   logic        refill_active = 1'b0;
   int          refill_cnt;
   int          refill_gap;
   addr_t       refill_base;

   dcache_top uut (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .cpu_dat_i      (cpu_dat_i),
      .cpu_bsel_i     (cpu_bsel_i),
      .cpu_ack_o      (cpu_ack_o),
      .cpu_dat_o      (cpu_dat_o),
      .cache_hit_o    (cache_hit_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o),
      .refill_we_i    (refill_we_i),
      .refill_dat_i   (refill_dat_i),
      .refill_done_o  (refill_done_o),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .spr_bus_ack_o  (spr_bus_ack_o)
   );

   dcache_checker chk (
      .clk           (clk),
      .rst           (rst),
      .cpu_req_i     (cpu_req_i),
      .cpu_we_i      (cpu_we_i),
      .cpu_adr_i     (cpu_adr_i),
      .wr_dat_i      (cpu_dat_i),
      .cpu_bsel_i    (cpu_bsel_i),
      .cpu_ack_i     (cpu_ack_o),
      .rd_dat_i      (cpu_dat_o),
      .cache_hit_i   (cache_hit_o),
      .refill_req_i  (refill_req_o),
      .refill_adr_i  (refill_adr_o),
      .refill_we_i   (refill_we_i),
      .refill_done_i (refill_done_o),
      .spr_stb_i     (spr_bus_stb_i),
      .spr_dat_i     (spr_bus_dat_i),
      .spr_ack_i     (spr_bus_ack_o),
      .err_count_o   (err_count)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic data_t fill_word(input addr_t a);
      return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
   endfunction

   function automatic data_t mem_read(input addr_t a);
      if (mem.exists(a[ADDR_WIDTH-1:2])) begin
         return mem[a[ADDR_WIDTH-1:2]];
      end
      return fill_word({a[ADDR_WIDTH-1:2], 2'b00});
   endfunction

   function automatic addr_t line_addr(input tag_t t, input set_idx_t s, input word_sel_t w);
      return {t, s, w, 2'b00};
   endfunction

   // Four tags over three sets force evictions
   function automatic addr_t pool_addr();
      tag_t      t;
      set_idx_t  s;
      word_sel_t w;
      t = tag_t'(22'h2a0 + $urandom_range(0, 3));
      s = set_idx_t'(5 * $urandom_range(0, 2) + 1);
      w = word_sel_t'($urandom_range(0, 3));
      return line_addr(t, s, w);
   endfunction

   // Hold one CPU request until its ack
   task automatic cpu_access(input logic we, input addr_t adr, input data_t dat,
                             input bsel_t bsel);
      data_t d;
      @(posedge clk);
      cpu_req_i  <= 1'b1;
      cpu_we_i   <= we;
      cpu_adr_i  <= adr;
      cpu_dat_i  <= dat;
      cpu_bsel_i <= bsel;
      do @(posedge clk); while (!cpu_ack_o);
      cpu_req_i <= 1'b0;
      cpu_we_i  <= 1'b0;
      // Memory takes every store since the cache is write-through
      if (we) begin
         d = mem_read(adr);
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (bsel[b]) begin
               d[8*b +: 8] = dat[8*b +: 8];
            end
         end
         mem[adr[ADDR_WIDTH-1:2]] = d;
      end
   endtask

   task automatic cpu_read(input addr_t adr);
      cpu_access(1'b0, adr, '0, '0);
   endtask

   task automatic spr_invalidate(input set_idx_t s, input logic flush);
      @(posedge clk);
      spr_bus_stb_i  <= 1'b1;
      spr_bus_we_i   <= 1'b1;
      spr_bus_addr_i <= flush ? SPR_DCBFR_ADDR : SPR_DCBIR_ADDR;
      spr_bus_dat_i  <= data_t'(s) << SET_LSB;
      do @(posedge clk); while (!spr_bus_ack_o);
      spr_bus_stb_i <= 1'b0;
      spr_bus_we_i  <= 1'b0;
   endtask

   task automatic random_op();
      int    kind;
      addr_t a;
      kind = $urandom_range(0, 99);
      a    = pool_addr();
      if (kind < 12) begin
         spr_invalidate(a[SET_LSB +: SET_WIDTH], kind[0]);
      end else if (kind < 45) begin
         cpu_access(1'b1, a, $urandom, bsel_t'($urandom_range(1, 15)));
      end else begin
         cpu_read(a);
      end
   endtask

   // Refill responder returns ascending words with random idle gaps
   always @(posedge clk) begin
      if (rst) begin
         refill_we_i   <= 1'b0;
         refill_active = 1'b0;
      end else if (refill_active) begin
         if (refill_cnt == WORDS_PER_LINE) begin
            refill_we_i   <= 1'b0;
            refill_active = 1'b0;
         end else if (refill_gap > 0) begin
            refill_we_i <= 1'b0;
            refill_gap--;
         end else begin
            refill_we_i  <= 1'b1;
            refill_dat_i <= mem_read(refill_base + addr_t'(4 * refill_cnt));
            refill_cnt++;
            refill_gap = $urandom_range(0, MAX_GAP);
         end
      end else if (refill_req_o) begin
         refill_active = 1'b1;
         refill_cnt    = 0;
         refill_base   = refill_adr_o;
         refill_gap    = $urandom_range(0, MAX_GAP);
      end
   end

   // Watchdog
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: the cache did not finish all operations in time");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'h83b3c4af));
      rst            = 1'b1;
      cpu_req_i      = 1'b0;
      cpu_we_i       = 1'b0;
      cpu_adr_i      = '0;
      cpu_dat_i      = '0;
      cpu_bsel_i     = '0;
      spr_bus_stb_i  = 1'b0;
      spr_bus_we_i   = 1'b0;
      spr_bus_addr_i = '0;
      spr_bus_dat_i  = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // Checker flags any spurious ack or refill on the quiet bus
      repeat (10) @(posedge clk);
      chk.finish_test("reset_idle");

      for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
         random_op();
      end
      chk.finish_test("random_ops");

      // Fill set 20 and touch A so that C evicts B
      cpu_read(line_addr(22'h100, 6'd20, 2'd0));
      cpu_read(line_addr(22'h101, 6'd20, 2'd1));
      cpu_read(line_addr(22'h100, 6'd20, 2'd2));
      cpu_read(line_addr(22'h102, 6'd20, 2'd3));
      cpu_read(line_addr(22'h100, 6'd20, 2'd1));
      cpu_read(line_addr(22'h101, 6'd20, 2'd0));
      cpu_access(1'b1, line_addr(22'h102, 6'd20, 2'd2), 32'ha5a5_5a5a, 4'b0110);
      cpu_read(line_addr(22'h102, 6'd20, 2'd2));
      chk.finish_test("lru_eviction");

      // Both lines must refill after the set is dropped
      cpu_read(line_addr(22'h200, 6'd30, 2'd0));
      cpu_read(line_addr(22'h201, 6'd30, 2'd3));
      spr_invalidate(6'd30, 1'b1);
      cpu_read(line_addr(22'h200, 6'd30, 2'd1));
      cpu_read(line_addr(22'h201, 6'd30, 2'd2));
      spr_invalidate(6'd30, 1'b0);
      cpu_read(line_addr(22'h201, 6'd30, 2'd0));
      repeat (4) @(posedge clk);
      chk.finish_test("set_invalidate");

      chk.report_totals();
      if (err_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/dcache_checker.sv
`default_nettype none

module dcache_checker
   import dcache_geom_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     cpu_req_i,
   input  logic     cpu_we_i,
   input  addr_t    cpu_adr_i,
   input  data_t    wr_dat_i,
   input  bsel_t    cpu_bsel_i,
   input  logic     cpu_ack_i,
   input  data_t    rd_dat_i,
   input  logic     cache_hit_i,
   input  logic     refill_req_i,
   input  addr_t    refill_adr_i,
   input  logic     refill_we_i,
   input  logic     refill_done_i,
   input  logic     spr_stb_i,
   input  data_t    spr_dat_i,
   input  logic     spr_ack_i,
   output int       err_count_o
);

   // Model of tags and valid bits per set and way
   logic  valid_m [NUM_SETS][NUM_WAYS];
   tag_t  tag_m   [NUM_SETS][NUM_WAYS];
   // High when way 0 was used last
   logic  lru_m   [NUM_SETS];
   // Expected memory holds only the written words
   data_t exp_mem [logic [ADDR_WIDTH-3:0]];

   int    n_checks = 0;
   int    n_errors = 0;
   int    mark_checks = 0;
   int    mark_errors = 0;

   // State of the request in flight
   logic  req_active;
   logic  pred_miss;
   logic  refill_seen;
   int    refill_words;

   assign err_count_o = n_errors;

   // Initial memory pattern mixing all address bits
   function automatic data_t fill_word(input addr_t a);
      return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
   endfunction

   function automatic data_t expected_word(input addr_t a);
      if (exp_mem.exists(a[ADDR_WIDTH-1:2])) begin
         return exp_mem[a[ADDR_WIDTH-1:2]];
      end
      return fill_word({a[ADDR_WIDTH-1:2], 2'b00});
   endfunction

   // Base of the 16-byte line that holds a byte address
   function automatic addr_t line_base(input addr_t a);
      return a - (a % addr_t'(BYTES_PER_WORD * WORDS_PER_LINE));
   endfunction

   function automatic int find_way(input set_idx_t s, input tag_t t);
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (valid_m[s][w] && tag_m[s][w] == t) begin
            return w;
         end
      end
      return -1;
   endfunction

   task automatic check(input logic ok, input string msg);
      n_checks++;
      if (!ok) begin
         n_errors++;
         $display("error at time %0t: %s", $time, msg);
      end
   endtask

   // One line per finished test
   task automatic finish_test(input string name);
      $display("test %s: %0d checks, %0d errors", name,
               n_checks - mark_checks, n_errors - mark_errors);
      mark_checks = n_checks;
      mark_errors = n_errors;
   endtask

   task automatic report_totals();
      $display("total: %0d checks, %0d errors", n_checks, n_errors);
   endtask

   // Compare on the falling edge while the outputs are stable
   always @(negedge clk) begin : watch
      set_idx_t s;
      tag_t     t;
      int       w;
      data_t    d;
      if (rst) begin
         for (int i = 0; i < NUM_SETS; i++) begin
            lru_m[i] = 1'b0;
            for (int j = 0; j < NUM_WAYS; j++) begin
               valid_m[i][j] = 1'b0;
            end
         end
         req_active   = 1'b0;
         pred_miss    = 1'b0;
         refill_seen  = 1'b0;
         refill_words = 0;
      end else begin
         s = cpu_adr_i[SET_LSB +: SET_WIDTH];
         t = cpu_adr_i[TAG_LSB +: TAG_WIDTH];
         // Outputs only allowed with a matching request
         check(!(cpu_ack_i && !cpu_req_i), "cpu ack seen without a request");
         check(!(spr_ack_i && !spr_stb_i), "spr ack seen without a strobe");
         check(!(refill_req_i && !(cpu_req_i && !cpu_we_i)),
               "refill request seen without a read");
         // Predict the lookup of a new request from the model
         if (cpu_req_i && !req_active) begin
            req_active  = 1'b1;
            refill_seen = 1'b0;
            pred_miss   = !cpu_we_i && (find_way(s, t) < 0);
         end
         if (refill_req_i && !refill_seen) begin
            refill_seen  = 1'b1;
            refill_words = 0;
            check(pred_miss, $sformatf("refill for %h on a predicted hit", cpu_adr_i));
            check(refill_adr_i == line_base(cpu_adr_i),
                  $sformatf("refill address %h for request %h", refill_adr_i, cpu_adr_i));
         end
         // Done pulses with the last refill word only
         check(refill_done_i == (refill_req_i && refill_we_i &&
                                 refill_words == WORDS_PER_LINE - 1),
               $sformatf("refill done %b after %0d refill words",
                         refill_done_i, refill_words));
         if (refill_req_i && refill_we_i) begin
            refill_words++;
         end
         // Line lands in the least recently used way
         if (refill_done_i) begin
            w = lru_m[s] ? 1 : 0;
            tag_m[s][w]   = t;
            valid_m[s][w] = 1'b1;
            lru_m[s]      = (w == 0);
         end
         if (cpu_ack_i && cpu_req_i) begin
            w = find_way(s, t);
            if (cpu_we_i) begin
               d = expected_word(cpu_adr_i);
               for (int b = 0; b < BYTES_PER_WORD; b++) begin
                  if (cpu_bsel_i[b]) begin
                     d[8*b +: 8] = wr_dat_i[8*b +: 8];
                  end
               end
               exp_mem[cpu_adr_i[ADDR_WIDTH-1:2]] = d;
            end else begin
               check(!pred_miss || refill_seen, "read miss acknowledged without refill");
               check(cache_hit_i && w >= 0, "read acknowledged without a hit");
               check(rd_dat_i == expected_word(cpu_adr_i),
                     $sformatf("read %h returned %h, expected %h",
                               cpu_adr_i, rd_dat_i, expected_word(cpu_adr_i)));
            end
            // Write miss leaves the LRU alone
            if (w >= 0) begin
               lru_m[s] = (w == 0);
            end
            req_active = 1'b0;
         end
         // Invalidate drops the whole set
         if (spr_ack_i && spr_stb_i) begin
            s = spr_dat_i[SET_LSB +: SET_WIDTH];
            lru_m[s] = 1'b0;
            for (int j = 0; j < NUM_WAYS; j++) begin
               valid_m[s][j] = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`default_nettype none

module dcache_top
   import dcache_geom_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   // CPU side
   input  logic        cpu_req_i,
   input  logic        cpu_we_i,
   input  addr_t       cpu_adr_i,
   input  data_t       cpu_dat_i,
   input  bsel_t       cpu_bsel_i,
   output logic        cpu_ack_o,
   output data_t       cpu_dat_o,
   output logic        cache_hit_o,

   // Refill side
   output logic        refill_req_o,
   output addr_t       refill_adr_o,
   input  logic        refill_we_i,
   input  data_t       refill_dat_i,
   output logic        refill_done_o,

   // SPR side
   input  logic        spr_bus_stb_i,
   input  logic        spr_bus_we_i,
   input  logic [15:0] spr_bus_addr_i,
   input  data_t       spr_bus_dat_i,
   output logic        spr_bus_ack_o
);

   dcache_way_if way_bus [NUM_WAYS] ();

   logic     any_hit;
   way_vec_t hit_way;
   data_t    hit_data;
   way_vec_t victim;
   logic     lru_we;
   set_idx_t lru_index;
   way_vec_t lru_access;

   dcache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .cpu_dat_i      (cpu_dat_i),
      .cpu_bsel_i     (cpu_bsel_i),
      .cpu_ack_o      (cpu_ack_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o),
      .refill_we_i    (refill_we_i),
      .refill_dat_i   (refill_dat_i),
      .refill_done_o  (refill_done_o),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .spr_bus_ack_o  (spr_bus_ack_o),
      .any_hit_i      (any_hit),
      .hit_way_i      (hit_way),
      .hit_data_i     (hit_data),
      .victim_i       (victim),
      .lru_we_o       (lru_we),
      .lru_index_o    (lru_index),
      .lru_access_o   (lru_access),
      .ways_o         (way_bus)
   );

   // One storage block per way
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_way u_way (
         .clk    (clk),
         .rst    (rst),
         .way_io (way_bus[w])
      );
   end

   dcache_lru_sel u_lru_sel (
      .clk          (clk),
      .rst          (rst),
      .ways_i       (way_bus),
      .lru_we_i     (lru_we),
      .lru_index_i  (lru_index),
      .lru_access_i (lru_access),
      .any_hit_o    (any_hit),
      .hit_way_o    (hit_way),
      .hit_data_o   (hit_data),
      .victim_o     (victim)
   );

   // Read data and hit flag come straight from the selector
   assign cpu_dat_o   = hit_data;
   assign cache_hit_o = any_hit;

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl
   import dcache_geom_pkg::*;
   import dcache_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   // CPU side
   input  logic        cpu_req_i,
   input  logic        cpu_we_i,
   input  addr_t       cpu_adr_i,
   input  data_t       cpu_dat_i,
   input  bsel_t       cpu_bsel_i,
   output logic        cpu_ack_o,

   // Refill side
   output logic        refill_req_o,
   output addr_t       refill_adr_o,
   input  logic        refill_we_i,
   input  data_t       refill_dat_i,
   output logic        refill_done_o,

   // SPR side
   input  logic        spr_bus_stb_i,
   input  logic        spr_bus_we_i,
   input  logic [15:0] spr_bus_addr_i,
   input  data_t       spr_bus_dat_i,
   output logic        spr_bus_ack_o,

   // From the hit and LRU selector
   input  logic        any_hit_i,
   input  way_vec_t    hit_way_i,
   input  data_t       hit_data_i,
   input  way_vec_t    victim_i,

   // LRU update
   output logic        lru_we_o,
   output set_idx_t    lru_index_o,
   output way_vec_t    lru_access_o,

   dcache_way_if.ctrl  ways_o [NUM_WAYS]
);

   ctrl_state_t state;

   // Way picked for replacement, frozen for the whole refill
   way_vec_t  victim_q;
   word_sel_t refill_cnt;
   logic      refill_last;

   set_idx_t  cpu_set;
   word_sel_t cpu_word;
   tag_t      cpu_tag;
   set_idx_t  inv_set;
   logic      invalidate;

   data_t     merged_dat;
   way_vec_t  data_we_vec;
   way_vec_t  tag_we_vec;
   set_idx_t  wr_index;
   word_sel_t wr_word;
   data_t     wr_data;
   logic      wr_valid;

   // Address fields of the held request
   assign cpu_set  = cpu_adr_i[SET_LSB +: SET_WIDTH];
   assign cpu_word = cpu_adr_i[WORD_LSB +: WORD_SEL_WIDTH];
   assign cpu_tag  = cpu_adr_i[TAG_LSB +: TAG_WIDTH];

   // SPR data carries an address, only its set field counts
   assign inv_set = spr_bus_dat_i[SET_LSB +: SET_WIDTH];

   // Block flush and block invalidate both drop the whole set
   assign invalidate = spr_bus_stb_i & spr_bus_we_i &
                       ((spr_bus_addr_i == SPR_DCBFR_ADDR) |
                        (spr_bus_addr_i == SPR_DCBIR_ADDR));

   assign refill_last = (refill_cnt == word_sel_t'(WORDS_PER_LINE - 1));

   // Read hit or any write finishes in the lookup cycle
   assign cpu_ack_o = ((state == READ) & any_hit_i) | (state == WRITE);

   assign refill_req_o  = (state == REFILL);
   assign refill_adr_o  = {cpu_adr_i[ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
   assign refill_done_o = (state == REFILL) & refill_we_i & refill_last;
   assign spr_bus_ack_o = (state == INVALIDATE);

   // Byte merge of store data over the stored word
   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         merged_dat[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : hit_data_i[8*b +: 8];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         refill_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               // SPR invalidate wins over a pending CPU request
               if (invalidate) begin
                  state <= INVALIDATE;
               end else if (cpu_req_i) begin
                  state <= cpu_we_i ? WRITE : READ;
               end
            end
            READ: begin
               if (any_hit_i) begin
                  state <= IDLE;
               end else begin
                  // Miss, remember the LRU way and fetch the line
                  state      <= REFILL;
                  victim_q   <= victim_i;
                  refill_cnt <= '0;
               end
            end
            WRITE: begin
               // Write-through, a miss does not allocate
               state <= IDLE;
            end
            REFILL: begin
               if (refill_we_i) begin
                  refill_cnt <= refill_cnt + 1'b1;
                  if (refill_last) begin
                     state <= IDLE;
                  end
               end
            end
            INVALIDATE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Way and LRU write controls
   always_comb begin
      data_we_vec  = '0;
      tag_we_vec   = '0;
      wr_index     = cpu_set;
      wr_word      = cpu_word;
      wr_data      = merged_dat;
      wr_valid     = 1'b0;
      lru_we_o     = 1'b0;
      lru_index_o  = cpu_set;
      lru_access_o = hit_way_i;

      case (state)
         READ: begin
            lru_we_o = any_hit_i;
         end
         WRITE: begin
            // Only the hit way takes the merged word
            if (any_hit_i) begin
               data_we_vec = hit_way_i;
               lru_we_o    = 1'b1;
            end
         end
         REFILL: begin
            if (refill_we_i) begin
               data_we_vec = victim_q;
               wr_word     = refill_cnt;
               wr_data     = refill_dat_i;
               // Old line is dropped as soon as its data starts to change
               if (refill_cnt == '0) begin
                  tag_we_vec = victim_q;
               end
               // New tag goes valid with the last word
               if (refill_last) begin
                  tag_we_vec   = victim_q;
                  wr_valid     = 1'b1;
                  lru_we_o     = 1'b1;
                  lru_access_o = victim_q;
               end
            end
         end
         INVALIDATE: begin
            wr_index     = inv_set;
            tag_we_vec   = '1;
            lru_we_o     = 1'b1;
            lru_index_o  = inv_set;
            // Empty access vector clears the history
            lru_access_o = '0;
         end
         default: begin
         end
      endcase
   end

   // Same lookup and write bus for every way, enables per way
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way_drv
      assign ways_o[w].rd_index = cpu_set;
      assign ways_o[w].rd_word  = cpu_word;
      assign ways_o[w].cmp_tag  = cpu_tag;
      assign ways_o[w].wr_index = wr_index;
      assign ways_o[w].wr_word  = wr_word;
      assign ways_o[w].wr_data  = wr_data;
      assign ways_o[w].wr_tag   = cpu_tag;
      assign ways_o[w].wr_valid = wr_valid;
      assign ways_o[w].data_we  = data_we_vec[w];
      assign ways_o[w].tag_we   = tag_we_vec[w];
   end

endmodule

`default_nettype wire

//--- verilog/dcache_lru_sel.sv
`default_nettype none

module dcache_lru_sel
   import dcache_geom_pkg::*;
(
   input  logic      clk,
   input  logic      rst,

   dcache_way_if.sel ways_i [NUM_WAYS],

   input  logic      lru_we_i,
   input  set_idx_t  lru_index_i,
   input  way_vec_t  lru_access_i,

   output logic      any_hit_o,
   output way_vec_t  hit_way_o,
   output data_t     hit_data_o,
   output way_vec_t  victim_o
);

   data_t     way_data [NUM_WAYS];

   // Pairwise history, bit set means the lower way is the more recent one
   lru_hist_t hist_mem [NUM_SETS];
   lru_hist_t cur_hist;
   lru_hist_t next_hist;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way_in
      assign hit_way_o[w] = ways_i[w].hit;
      assign way_data[w]  = ways_i[w].rd_data;
   end

   assign any_hit_o = |hit_way_o;

   // AND-OR mux, hit vector is one-hot or empty
   always_comb begin
      hit_data_o = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         hit_data_o = hit_data_o | (way_data[w] & {DATA_WIDTH{hit_way_o[w]}});
      end
   end

   assign cur_hist = hist_mem[lru_index_i];

   // Victim and history update from one walk over all way pairs
   always_comb begin
      int k;
      k         = 0;
      victim_o  = '1;
      next_hist = cur_hist;
      for (int i = 0; i < NUM_WAYS; i++) begin
         for (int j = i + 1; j < NUM_WAYS; j++) begin
            // The more recent way of each pair cannot be the victim
            if (cur_hist[k]) begin
               victim_o[i] = 1'b0;
            end else begin
               victim_o[j] = 1'b0;
            end
            // Accessed way becomes newer than its partner
            if (lru_access_i[i]) begin
               next_hist[k] = 1'b1;
            end else if (lru_access_i[j]) begin
               next_hist[k] = 1'b0;
            end
            k++;
         end
      end
      // No access named, the set starts over
      if (lru_access_i == '0) begin
         next_hist = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < NUM_SETS; s++) begin
            hist_mem[s] <= '0;
         end
      end else if (lru_we_i) begin
         hist_mem[lru_index_i] <= next_hist;
      end
   end

endmodule

`default_nettype wire

//--- verilog/dcache_way.sv
`default_nettype none

module dcache_way
   import dcache_geom_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   dcache_way_if.way way_io
);

   // Data array addressed by set and word
   typedef logic [SET_WIDTH+WORD_SEL_WIDTH-1:0] data_idx_t;

   data_t     data_mem [NUM_SETS*WORDS_PER_LINE];
   tag_t      tag_mem  [NUM_SETS];
   logic [NUM_SETS-1:0] valid;

   data_idx_t rd_idx;
   data_idx_t wr_idx;

   // Set seen by the last lookup, tag compare works on it
   set_idx_t  rd_set_q;
   tag_t      stored_tag;
   logic      stored_valid;

   assign rd_idx = {way_io.rd_index, way_io.rd_word};
   assign wr_idx = {way_io.wr_index, way_io.wr_word};

   // Registered read, data shows up one cycle after the address
   always_ff @(posedge clk) begin
      way_io.rd_data <= data_mem[rd_idx];
      if (way_io.data_we) begin
         data_mem[wr_idx] <= way_io.wr_data;
      end
   end

   always_ff @(posedge clk) begin
      rd_set_q <= way_io.rd_index;
      if (way_io.tag_we) begin
         tag_mem[way_io.wr_index] <= way_io.wr_tag;
      end
   end

   // Valid bits are the only state that reset touches
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (way_io.tag_we) begin
         valid[way_io.wr_index] <= way_io.wr_valid;
      end
   end

   assign stored_tag   = tag_mem[rd_set_q];
   assign stored_valid = valid[rd_set_q];

   // Hit needs a valid line with matching tag
   assign way_io.hit = stored_valid & (stored_tag == way_io.cmp_tag);

endmodule

`default_nettype wire

//--- verilog/dcache_way_if.sv
`default_nettype none

interface dcache_way_if
   import dcache_geom_pkg::*;
();

   // Lookup side
   set_idx_t  rd_index;
   word_sel_t rd_word;
   tag_t      cmp_tag;

   // Write side, shared by hit writes, refill and invalidate
   set_idx_t  wr_index;
   word_sel_t wr_word;
   data_t     wr_data;
   logic      data_we;
   logic      tag_we;
   tag_t      wr_tag;
   logic      wr_valid;

   // Results of the way
   logic      hit;
   data_t     rd_data;

   modport ctrl (
      output rd_index, rd_word, cmp_tag,
      output wr_index, wr_word, wr_data, data_we, tag_we, wr_tag, wr_valid
   );

   modport way (
      input  rd_index, rd_word, cmp_tag,
      input  wr_index, wr_word, wr_data, data_we, tag_we, wr_tag, wr_valid,
      output hit, rd_data
   );

   modport sel (
      input hit, rd_data
   );

endinterface

`default_nettype wire

//--- verilog/dcache_ctrl_pkg.sv
`default_nettype none

package dcache_ctrl_pkg;

   // Cache controller states
   typedef enum logic [2:0] {
      IDLE,
      READ,
      WRITE,
      REFILL,
      INVALIDATE
   } ctrl_state_t;

   // Data cache SPR group, block flush and block invalidate
   localparam logic [15:0] SPR_DCBFR_ADDR = 16'h1802;
   localparam logic [15:0] SPR_DCBIR_ADDR = 16'h1803;

endpackage

`default_nettype wire

//--- verilog/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

   // Bus widths
   localparam int ADDR_WIDTH     = 32;
   localparam int DATA_WIDTH     = 32;
   localparam int BYTES_PER_WORD = DATA_WIDTH / 8;

   // Associativity
   localparam int NUM_WAYS = 2;

   // Line of 16 bytes, 4 words
   localparam int BLOCK_WIDTH    = 4;
   localparam int WORD_SEL_WIDTH = 2;
   localparam int WORDS_PER_LINE = 1 << WORD_SEL_WIDTH;

   // 64 sets per way
   localparam int SET_WIDTH = 6;
   localparam int NUM_SETS  = 1 << SET_WIDTH;

   // Tag takes whatever is left above index and offset
   localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;

   // Field positions inside a byte address
   localparam int WORD_LSB = BLOCK_WIDTH - WORD_SEL_WIDTH;
   localparam int SET_LSB  = BLOCK_WIDTH;
   localparam int TAG_LSB  = BLOCK_WIDTH + SET_WIDTH;

   // One history bit for every pair of ways
   localparam int LRU_WIDTH = NUM_WAYS * (NUM_WAYS - 1) / 2;

   typedef logic [ADDR_WIDTH-1:0]     addr_t;
   typedef logic [DATA_WIDTH-1:0]     data_t;
   typedef logic [BYTES_PER_WORD-1:0] bsel_t;
   typedef logic [SET_WIDTH-1:0]      set_idx_t;
   typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;
   typedef logic [TAG_WIDTH-1:0]      tag_t;
   typedef logic [NUM_WAYS-1:0]       way_vec_t;
   typedef logic [LRU_WIDTH-1:0]      lru_hist_t;

endpackage

`default_nettype wire
